// ==== hdl/microCpu_macros.svh ====
// Widths and microword field positions for the microcoded 8-bit CPU
// Shared by the package and every module of the core
`ifndef MICROCPU_MACROS_SVH
`define MICROCPU_MACROS_SVH

// Data path and instruction byte width
`define DATA_W 8

// Control store geometry
`define CS_DEPTH 256
`define UADDR_W ($clog2(`CS_DEPTH))
`define UWORD_W 24

// Low bit of each microword field, next-address nibbles at the bottom
`define NEXT_LOW_LSB 0
`define NEXT_HIGH_LSB 4
`define COUNT_BIT 8
`define BOP_LSB 9
`define ASRC_BIT 13
`define ALUFUNC_LSB 15
`define CIN_BIT 20
`define ALUDEST_LSB 21

// Field widths follow from the positions above
//   aSource 13, bSource 14, cin 20 are single bits
//   aluDest runs from 21 up to the top of the word

`endif

// ==== hdl/microCpuPkg.sv ====
// Shared types for the microcoded CPU
// Microword layout, operation encodings and status bundle
`default_nettype none

`include "microCpu_macros.svh"

package microCpuPkg;

        // ALU operations, cin feeds ADD and SUB
        typedef enum logic [`CIN_BIT-`ALUFUNC_LSB-1:0] {
                PASS_A,
                PASS_B,
                ADD,
                SUB,
                AND_OP,
                OR_OP,
                XOR_OP,
                NOT_A,
                ZERO
        } aluFuncE;

        // Where the ALU result lands
        typedef enum logic [`UWORD_W-`ALUDEST_LSB-1:0] {
                DEST_NONE,
                DEST_ACC,
                DEST_B,
                DEST_CNT,
                DEST_OUT
        } aluDestE;

        // Sequencer branch operations
        typedef enum logic [`ASRC_BIT-`BOP_LSB-1:0] {
                NEXT,
                JUMP,
                JNZCNT,
                JZ,
                END
        } bopE;

        // High nibble of the instruction byte
        typedef enum logic [`DATA_W/2-1:0] {
                LDI, ADDI, SUBI, ANDI, ORI, XORI,
                MOVB, ADDB, SUBB,
                NOTA, CLR, OUT, MULI,
                NOP0, NOP1, NOP2
        } opcodeE;

        typedef enum logic {IDLE, RUN} seqStateE;

        typedef struct packed {
                aluDestE                                     aluDest;
                logic                                        cin;
                aluFuncE                                     aluFunc;
                logic                                        bSource;
                logic                                        aSource;
                bopE                                         bop;
                logic                                        count;
                logic [`COUNT_BIT-`NEXT_HIGH_LSB-1:0]        nextHigh;
                logic [`NEXT_HIGH_LSB-`NEXT_LOW_LSB-1:0]     nextLow;
        } microWordT;

        // Flags the datapath hands back to the sequencer
        typedef struct packed {
                logic zero;
                logic cntZero;
        } dpStatusT;

endpackage

`default_nettype wire

// ==== hdl/controlStore.sv ====
// Microcode ROM of the CPU
// 256 words of 24 bits, read combinationally by microaddress
`timescale 1ns/1ps
`default_nettype none

`include "microCpu_macros.svh"

module controlStore (
        input  logic [`UADDR_W-1:0]     microaddress,
        output microCpuPkg::microWordT  microword
);
        import microCpuPkg::*;

        // Operand selects
        localparam logic ASelAcc = 1'b0;
        localparam logic BSelReg = 1'b0;
        localparam logic BSelImm = 1'b1;

        // MULI loop layout inside its 16-word slot
        localparam logic [`UADDR_W-1:0] MulHead = {MULI, 4'h2};
        localparam logic [`UADDR_W-1:0] MulAdd  = {MULI, 4'h4};

        function automatic microWordT uWord(input aluDestE dest,
                                            input aluFuncE func,
                                            input logic aSrc,
                                            input logic bSrc,
                                            input logic cin,
                                            input bopE bop,
                                            input logic count,
                                            input logic [`UADDR_W-1:0] next);
                microWordT w;
                w.aluDest = dest;
                w.cin     = cin;
                w.aluFunc = func;
                w.bSource = bSrc;
                w.aSource = aSrc;
                w.bop     = bop;
                w.count   = count;
                {w.nextHigh, w.nextLow} = next;
                return w;
        endfunction

        always_comb begin
                case (microaddress)
                        // Immediate forms, accumulator op zero-extended nibble
                        {LDI, 4'h0}:
                                microword = uWord(DEST_ACC, PASS_B, ASelAcc, BSelImm, 1'b0,
                                                  END, 1'b0, '0);
                        {ADDI, 4'h0}:
                                microword = uWord(DEST_ACC, ADD, ASelAcc, BSelImm, 1'b0,
                                                  END, 1'b0, '0);
                        {SUBI, 4'h0}:
                                microword = uWord(DEST_ACC, SUB, ASelAcc, BSelImm, 1'b1,
                                                  END, 1'b0, '0);
                        {ANDI, 4'h0}:
                                microword = uWord(DEST_ACC, AND_OP, ASelAcc, BSelImm, 1'b0,
                                                  END, 1'b0, '0);
                        {ORI, 4'h0}:
                                microword = uWord(DEST_ACC, OR_OP, ASelAcc, BSelImm, 1'b0,
                                                  END, 1'b0, '0);
                        {XORI, 4'h0}:
                                microword = uWord(DEST_ACC, XOR_OP, ASelAcc, BSelImm, 1'b0,
                                                  END, 1'b0, '0);

                        // Register forms against B
                        {MOVB, 4'h0}:
                                microword = uWord(DEST_B, PASS_A, ASelAcc, BSelReg, 1'b0,
                                                  END, 1'b0, '0);
                        {ADDB, 4'h0}:
                                microword = uWord(DEST_ACC, ADD, ASelAcc, BSelReg, 1'b0,
                                                  END, 1'b0, '0);
                        {SUBB, 4'h0}:
                                microword = uWord(DEST_ACC, SUB, ASelAcc, BSelReg, 1'b1,
                                                  END, 1'b0, '0);
                        {NOTA, 4'h0}:
                                microword = uWord(DEST_ACC, NOT_A, ASelAcc, BSelReg, 1'b0,
                                                  END, 1'b0, '0);
                        {CLR, 4'h0}:
                                microword = uWord(DEST_ACC, ZERO, ASelAcc, BSelReg, 1'b0,
                                                  END, 1'b0, '0);
                        {OUT, 4'h0}:
                                microword = uWord(DEST_OUT, PASS_A, ASelAcc, BSelReg, 1'b0,
                                                  END, 1'b0, '0);

                        // Multiply by repeated add: counter from imm, B keeps the multiplicand
                        {MULI, 4'h0}:
                                microword = uWord(DEST_CNT, PASS_B, ASelAcc, BSelImm, 1'b0,
                                                  NEXT, 1'b0, '0);
                        {MULI, 4'h1}:
                                microword = uWord(DEST_ACC, ZERO, ASelAcc, BSelReg, 1'b0,
                                                  NEXT, 1'b0, '0);
                        MulHead:
                                microword = uWord(DEST_NONE, PASS_A, ASelAcc, BSelReg, 1'b0,
                                                  JNZCNT, 1'b0, MulAdd);
                        {MULI, 4'h3}:
                                microword = uWord(DEST_NONE, PASS_A, ASelAcc, BSelReg, 1'b0,
                                                  END, 1'b0, '0);
                        MulAdd:
                                microword = uWord(DEST_ACC, ADD, ASelAcc, BSelReg, 1'b0,
                                                  JUMP, 1'b1, MulHead);

                        // NOP codes and unused words finish without a write
                        default:
                                microword = uWord(DEST_NONE, ZERO, ASelAcc, BSelReg, 1'b0,
                                                  END, 1'b0, '0);
                endcase
        end

endmodule

`default_nettype wire

// ==== hdl/microSequencer.sv ====
// Microprogram sequencer of the CPU
// Dispatches an instruction to opcode*16 and walks its microprogram by bop
`timescale 1ns/1ps
`default_nettype none

`include "microCpu_macros.svh"

module microSequencer (
        input  logic                    clk,
        input  logic                    rstN,
        input  logic                    instrStrobe,
        input  logic [`DATA_W-1:0]      instr,
        input  microCpuPkg::microWordT  microword,
        input  microCpuPkg::dpStatusT   status,
        output logic [`UADDR_W-1:0]     microaddress,
        output logic [`DATA_W/2-1:0]    imm,
        output logic                    busy,
        output logic                    done
);
        import microCpuPkg::*;

        seqStateE               state;
        opcodeE                 opcode;
        logic [`UADDR_W-1:0]    jumpAddr;
        logic [`UADDR_W-1:0]    incrAddr;
        logic [`UADDR_W-1:0]    nextAddr;
        logic                   endOfProgram;
        logic                   dispatch;

        assign opcode   = opcodeE'(instr[`DATA_W-1:`DATA_W/2]);
        assign jumpAddr = {microword.nextHigh, microword.nextLow};
        assign incrAddr = microaddress + `UADDR_W'(1);
        assign dispatch = (state == IDLE) && instrStrobe;
        assign busy     = (state == RUN);

        // Branch resolution for the word now executing
        always_comb begin
                nextAddr     = incrAddr;
                endOfProgram = 1'b0;
                case (microword.bop)
                        NEXT:
                                nextAddr = incrAddr;
                        JUMP:
                                nextAddr = jumpAddr;
                        JNZCNT:
                                if (!status.cntZero)
                                        nextAddr = jumpAddr;
                        JZ:
                                if (status.zero)
                                        nextAddr = jumpAddr;
                        default:
                                endOfProgram = 1'b1;    // END and undefined codes
                endcase
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        state        <= IDLE;
                        microaddress <= '0;
                        done         <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                                IDLE: begin
                                        // Strobes during RUN never reach here
                                        if (instrStrobe) begin
                                                state        <= RUN;
                                                microaddress <= {opcode, 4'h0};
                                        end
                                end
                                RUN: begin
                                        if (endOfProgram) begin
                                                state <= IDLE;
                                                done  <= 1'b1;
                                        end else begin
                                                microaddress <= nextAddr;
                                        end
                                end
                        endcase
                end
        end

        // Immediate nibble held for the whole microprogram
        always_ff @(posedge clk) begin
                if (dispatch)
                        imm <= instr[`DATA_W/2-1:0];
        end

endmodule

`default_nettype wire

// ==== hdl/aluDatapath.sv ====
// Datapath of the CPU
// Accumulator, B register, loop counter, ALU and output register
`timescale 1ns/1ps
`default_nettype none

`include "microCpu_macros.svh"

module aluDatapath (
        input  logic                    clk,
        input  logic                    rstN,
        input  logic                    run,
        input  microCpuPkg::microWordT  microword,
        input  logic [`DATA_W/2-1:0]    imm,
        output microCpuPkg::dpStatusT   status,
        output logic                    outValid,
        output logic [`DATA_W-1:0]      outData
);
        import microCpuPkg::*;

        logic [`DATA_W-1:0] acc;
        logic [`DATA_W-1:0] bReg;
        logic [`DATA_W-1:0] cnt;
        logic [`DATA_W-1:0] immExt;
        logic [`DATA_W-1:0] cinExt;
        logic [`DATA_W-1:0] aOp;
        logic [`DATA_W-1:0] bOp;
        logic [`DATA_W-1:0] aluResult;
        logic               zeroReg;

        assign immExt = {{(`DATA_W-`DATA_W/2){1'b0}}, imm};
        assign cinExt = {{(`DATA_W-1){1'b0}}, microword.cin};

        assign aOp = microword.aSource ? bReg : acc;
        assign bOp = microword.bSource ? immExt : bReg;

        always_comb begin
                case (microword.aluFunc)
                        PASS_A: aluResult = aOp;
                        PASS_B: aluResult = bOp;
                        ADD:    aluResult = aOp + bOp + cinExt;
                        // a + ~b + 1 gives a - b
                        SUB:    aluResult = aOp + ~bOp + cinExt;
                        AND_OP: aluResult = aOp & bOp;
                        OR_OP:  aluResult = aOp | bOp;
                        XOR_OP: aluResult = aOp ^ bOp;
                        NOT_A:  aluResult = ~aOp;
                        default: aluResult = '0;
                endcase
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        acc      <= '0;
                        bReg     <= '0;
                        cnt      <= '0;
                        zeroReg  <= 1'b1;
                        outValid <= 1'b0;
                end else begin
                        outValid <= 1'b0;
                        if (run) begin
                                if (microword.count)
                                        cnt <= cnt - `DATA_W'(1);
                                case (microword.aluDest)
                                        DEST_ACC: begin
                                                acc     <= aluResult;
                                                zeroReg <= (aluResult == '0);
                                        end
                                        DEST_B:
                                                bReg <= aluResult;
                                        DEST_CNT: begin
                                                // Loop setup also copies the A operand into B
                                                cnt  <= aluResult;
                                                bReg <= aOp;
                                        end
                                        DEST_OUT:
                                                outValid <= 1'b1;
                                        default: ;
                                endcase
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (run && microword.aluDest == DEST_OUT)
                        outData <= aluResult;
        end

        assign status.zero    = zeroReg;
        assign status.cntZero = (cnt == '0);

endmodule

`default_nettype wire

// ==== hdl/microCpu.sv ====
// Top level of the microcoded 8-bit CPU
// Sequencer and datapath run side by side on each control-store word
`timescale 1ns/1ps
`default_nettype none

`include "microCpu_macros.svh"

module microCpu (
        input  logic                clk,
        input  logic                rstN,
        input  logic                instrStrobe,
        input  logic [`DATA_W-1:0]  instr,
        output logic                busy,
        output logic                done,
        output logic                outValid,
        output logic [`DATA_W-1:0]  outData,
        output logic                zeroFlag
);
        import microCpuPkg::*;

        logic [`UADDR_W-1:0]    microaddress;
        logic [`DATA_W/2-1:0]   imm;
        microWordT              microword;
        dpStatusT               status;

        microSequencer i_sequencer (
                .clk          (clk),
                .rstN         (rstN),
                .instrStrobe  (instrStrobe),
                .instr        (instr),
                .microword    (microword),
                .status       (status),
                .microaddress (microaddress),
                .imm          (imm),
                .busy         (busy),
                .done         (done)
        );

        controlStore i_controlStore (
                .microaddress (microaddress),
                .microword    (microword)
        );

        // Datapath only acts on words while a microprogram runs
        aluDatapath i_datapath (
                .clk       (clk),
                .rstN      (rstN),
                .run       (busy),
                .microword (microword),
                .imm       (imm),
                .status    (status),
                .outValid  (outValid),
                .outData   (outData)
        );

        assign zeroFlag = status.zero;

endmodule

`default_nettype wire

// ==== test/microCpuTb.sv ====
// Testbench for the microcoded 8-bit CPU
// Runs instruction sequences against a reference model of acc and B
`timescale 1ns/1ps
`default_nettype none

`include "microCpu_macros.svh"

module microCpuTb;
        import microCpuPkg::*;

        localparam int ClkPeriod   = 10;
        localparam int DoneLimit   = 40;
        // Worst-case MULI length in cycles, imm = 15
        localparam int MuliWorst   = 3 + 2 * 15;
        // Upper bound on instructions issued by all tests
        localparam int InstrBudget = 130;
        localparam int WatchdogNs  = InstrBudget * (MuliWorst + 4) * ClkPeriod + 2000;

        logic               clk;
        logic               rstN;
        logic               instrStrobe;
        logic [`DATA_W-1:0] instr;
        logic               busy;
        logic               done;
        logic               outValid;
        logic [`DATA_W-1:0] outData;
        logic               zeroFlag;

        logic [`DATA_W-1:0] modelAcc;
        logic [`DATA_W-1:0] modelB;
        int                 errCount;
        int                 checkCount;
        int                 testCount;
        int                 testFailCount;
        int                 errAtStart;
        int                 cycles;
        int                 donePulses;
        logic [3:0]         immA;
        logic [3:0]         immB;
        opcodeE             singleOps [8];

        microCpu i_dut (
                .clk         (clk),
                .rstN        (rstN),
                .instrStrobe (instrStrobe),
                .instr       (instr),
                .busy        (busy),
                .done        (done),
                .outValid    (outValid),
                .outData     (outData),
                .zeroFlag    (zeroFlag)
        );

        initial clk = 1'b0;
        always #(ClkPeriod / 2) clk = ~clk;

        task automatic checkBit(input string name, input logic expected, input logic actual);
                checkCount++;
                assert (actual === expected) else begin
                        errCount++;
                        $display("[ERROR] %0t ns: %s expected %b actual %b",
                                 $time, name, expected, actual);
                end
        endtask

        task automatic checkByte(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
                checkCount++;
                assert (actual === expected) else begin
                        errCount++;
                        $display("[ERROR] %0t ns: %s expected 0x%02h actual 0x%02h",
                                 $time, name, expected, actual);
                end
        endtask

        // Reference behavior of each opcode, 8-bit wrap-around
        task automatic applyModel(input opcodeE op, input logic [3:0] immVal);
                logic [7:0] immExt;
                immExt = {4'h0, immVal};
                case (op)
                        LDI:  modelAcc = immExt;
                        ADDI: modelAcc = modelAcc + immExt;
                        SUBI: modelAcc = modelAcc - immExt;
                        ANDI: modelAcc = modelAcc & immExt;
                        ORI:  modelAcc = modelAcc | immExt;
                        XORI: modelAcc = modelAcc ^ immExt;
                        MOVB: modelB = modelAcc;
                        ADDB: modelAcc = modelAcc + modelB;
                        SUBB: modelAcc = modelAcc - modelB;
                        NOTA: modelAcc = ~modelAcc;
                        CLR:  modelAcc = 8'h00;
                        MULI: begin
                                modelB   = modelAcc;
                                modelAcc = 8'(modelAcc * immExt);
                        end
                        default: ;
                endcase
        endtask

        // Strobe one instruction, then wait for done; starts 1 ns after an edge
        task automatic issue(input opcodeE op, input logic [3:0] immVal, output int waited);
                instrStrobe = 1'b1;
                instr       = {op, immVal};
                waited      = 0;
                do begin
                        @(posedge clk);
                        #1;
                        instrStrobe = 1'b0;
                        waited++;
                end while (!done && waited < DoneLimit);
                if (!done) begin
                        errCount++;
                        $display("%0t ns: no done pulse within %0d cycles for opcode %s",
                                 $time, DoneLimit, op.name());
                end
        endtask

        task automatic runAndCheck(input opcodeE op, input logic [3:0] immVal,
                                   output int waited);
                issue(op, immVal, waited);
                applyModel(op, immVal);
                checkBit("busy", 1'b0, busy);
                checkBit("zeroFlag", modelAcc == 8'h00, zeroFlag);
                checkBit("outValid", op == OUT, outValid);
                if (op == OUT)
                        checkByte("outData", modelAcc, outData);
        endtask

        task automatic finishTest(input string name);
                int failures;
                failures = errCount - errAtStart;
                testCount++;
                if (failures == 0) begin
                        $display("test %-14s passed", name);
                end else begin
                        testFailCount++;
                        $display("test %-14s failed with %0d errors", name, failures);
                end
                errAtStart = errCount;
        endtask

        initial begin
                #(WatchdogNs);
                $display("Watchdog expired after %0d ns, DUT stopped responding", WatchdogNs);
                $display("** FAIL **");
                $finish;
        end

        initial begin
                void'($urandom(73));
                singleOps = '{LDI, ADDI, SUBI, ANDI, ORI, XORI, NOTA, CLR};
                errCount = 0;
                checkCount = 0;
                testCount = 0;
                testFailCount = 0;
                errAtStart = 0;
                modelAcc = 8'h00;
                modelB = 8'h00;
                rstN = 1'b0;
                instrStrobe = 1'b0;
                instr = 8'h00;
                repeat (2) @(posedge clk);
                #1;
                rstN = 1'b1;

                // Reset values
                checkBit("busy", 1'b0, busy);
                checkBit("done", 1'b0, done);
                checkBit("outValid", 1'b0, outValid);
                checkBit("zeroFlag", 1'b1, zeroFlag);
                runAndCheck(OUT, 4'h0, cycles);
                finishTest("reset");

                for (int round = 0; round < 3; round++) begin
                        foreach (singleOps[i]) begin
                                immA = 4'($urandom_range(15, 0));
                                runAndCheck(singleOps[i], immA, cycles);
                                checkByte("done latency", 8'd2, 8'(cycles));
                                runAndCheck(OUT, 4'h0, cycles);
                                checkByte("done latency", 8'd2, 8'(cycles));
                        end
                end
                finishTest("single-step");

                for (int round = 0; round < 2; round++) begin
                        immA = 4'($urandom_range(15, 0));
                        immB = 4'($urandom_range(15, 0));
                        runAndCheck(LDI, immA, cycles);
                        runAndCheck(MOVB, 4'h0, cycles);
                        runAndCheck(LDI, immB, cycles);
                        runAndCheck(ADDB, 4'h0, cycles);
                        runAndCheck(OUT, 4'h0, cycles);
                        runAndCheck(SUBB, 4'h0, cycles);
                        runAndCheck(OUT, 4'h0, cycles);
                        runAndCheck(SUBB, 4'h0, cycles);
                end
                finishTest("register ops");

                // Both loop extremes first, then random multipliers
                for (int round = 0; round < 8; round++) begin
                        immA = 4'($urandom_range(15, 1));
                        immB = (round == 0) ? 4'hF : (round == 1) ? 4'h0
                                : 4'($urandom_range(15, 0));
                        runAndCheck(LDI, immA, cycles);
                        runAndCheck(MULI, immB, cycles);
                        runAndCheck(OUT, 4'h0, cycles);
                        runAndCheck(MULI, 4'($urandom_range(15, 0)), cycles);
                        runAndCheck(OUT, 4'h0, cycles);
                end
                finishTest("multiply");

                runAndCheck(LDI, 4'h7, cycles);
                runAndCheck(SUBI, 4'h7, cycles);
                runAndCheck(ADDI, 4'h1, cycles);
                runAndCheck(SUBI, 4'h1, cycles);
                runAndCheck(NOTA, 4'h0, cycles);
                runAndCheck(CLR, 4'h0, cycles);
                finishTest("zero flag");

                // Second strobe lands while MULI runs and must be dropped
                runAndCheck(LDI, 4'h3, cycles);
                instrStrobe = 1'b1;
                instr = {MULI, 4'h5};
                @(posedge clk);
                #1;
                checkBit("busy", 1'b1, busy);
                instr = {LDI, 4'hA};
                @(posedge clk);
                #1;
                instrStrobe = 1'b0;
                donePulses = 0;
                for (int waited = 0; waited < DoneLimit + 5; waited++) begin
                        if (done)
                                donePulses++;
                        @(posedge clk);
                        #1;
                end
                applyModel(MULI, 4'h5);
                checkByte("done pulses", 8'd1, 8'(donePulses));
                checkBit("zeroFlag", modelAcc == 8'h00, zeroFlag);
                runAndCheck(OUT, 4'h0, cycles);
                finishTest("busy strobe");

                $display("tests %0d, failed %0d, checks %0d, errors %0d",
                         testCount, testFailCount, checkCount, errCount);
                if (errCount == 0)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/microCpuPkg.sv
hdl/controlStore.sv
hdl/microSequencer.sv
hdl/aluDatapath.sv
hdl/microCpu.sv
test/microCpuTb.sv

// ==== Makefile ====
# Verilator flow for the microcoded CPU and its testbench

VERILATOR ?= verilator
TOP       ?= microCpuTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

build: $(BUILD_DIR)/V$(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
